/* Makefile */
# lint, simulate and clean the fpu coprocessor with verilator
TOP = tb_fpu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f src.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

/* hdl/fpu_addsub.sv */
// add/sub stage: combines the aligned mantissas, normalizes and registers the result
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_addsub (
  input  logic              clk,
  input  logic              arst,
  input  fpu_pkg::aligned_t stage,
  input  logic              stage_valid,
  output fpu_pkg::ieee_t    sum,
  output logic              sum_valid
);

  localparam int EW   = `FPU_EXP_W;
  localparam int MW   = `FPU_MANT_W;
  localparam int FW   = `FPU_FRAC_W;
  localparam int LZ_W = $clog2(`FPU_FRAC_W + 2);

  logic            is_sub;
  logic            take;
  logic [MW-1:0]   total;
  logic [MW-1:0]   mag;
  logic [MW-1:0]   norm;
  logic [LZ_W-1:0] lz;
  logic [EW-1:0]   exp_n;
  fpu_pkg::ieee_t  next_sum;

  assign is_sub = stage.op == fpu_pkg::OP_SUB;
  assign take   = stage_valid && stage.op != fpu_pkg::OP_MUL;
  assign total  = is_sub ? stage.a_mant - stage.b_mant : stage.a_mant + stage.b_mant;
  assign mag    = total[MW-1] ? -total : total;

  // distance of the top set bit from the hidden bit position
  always_comb begin
    lz = '0;
    for (int i = 0; i <= FW; i++) begin
      if (mag[i]) lz = LZ_W'(FW - i);
    end
  end

  always_comb begin
    norm  = mag;
    exp_n = stage.exp;
    if (mag[MW-1]) begin
      norm  = mag >> 2;
      exp_n = stage.exp + EW'(2);
    end else if (mag[MW-2]) begin
      norm  = mag >> 1;
      exp_n = stage.exp + EW'(1);
    end else begin
      norm  = mag << lz;
      exp_n = stage.exp - EW'(lz);
    end
    if (total == '0) next_sum = '0;
    // a is zero, pass b through unchanged apart from the sign
    else if (stage.a_zero) next_sum = '{sign: stage.b_sign ^ is_sub,
                                        exp: stage.b_exp + EW'(`FPU_BIAS),
                                        frac: stage.b_raw[FW-1:0]};
    else next_sum = '{sign: total[MW-1], exp: exp_n + EW'(`FPU_BIAS), frac: norm[FW-1:0]};
  end

  always_ff @(posedge clk or posedge arst) begin
    if (arst) sum_valid <= 1'b0;
    else sum_valid <= take;
  end

  always_ff @(posedge clk) begin
    if (take) sum <= next_sum;
  end

endmodule

/* hdl/fpu_config.svh */
// format widths, bus map and opcodes for the fpu, included by the package and the rtl modules
`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// single-precision format
`define FPU_WIDTH      32
`define FPU_EXP_W      8
`define FPU_FRAC_W     23
`define FPU_BIAS       127

// 24-bit mantissa plus sign and carry guard bits
`define FPU_MANT_W     26

// shift-and-add iterations, one per multiplier bit
`define FPU_MUL_STEPS  24

// register bus map
`define FPU_ADDR_OPA0  4'h0
`define FPU_ADDR_OPB0  4'h4
`define FPU_ADDR_OP    4'h8
`define FPU_ADDR_START 4'h9
`define FPU_ADDR_RES0  4'h9

// operation codes
`define FPU_OP_ADD     4'd0
`define FPU_OP_SUB     4'd1
`define FPU_OP_MUL     4'd2

`endif

/* hdl/fpu_mul.sv */
// multiply stage: iterative shift-and-add on the mantissas with exponent sum and normalization
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_mul (
  input  logic              clk,
  input  logic              arst,
  input  fpu_pkg::aligned_t stage,
  input  logic              stage_valid,
  output fpu_pkg::ieee_t    product,
  output logic              product_valid
);

  localparam int EW = `FPU_EXP_W;
  localparam int FW = `FPU_FRAC_W;
  localparam int RW = `FPU_FRAC_W + 1;
  localparam int PW = 2 * RW + 1;
  localparam int CW = $clog2(`FPU_MUL_STEPS + 1);

  logic           running;
  logic           shift_ph;
  logic [CW-1:0]  step;
  logic           start;
  logic           last;
  // upper half accumulates, lower half holds what is left of the multiplier
  logic [PW-1:0]  acc;
  logic [RW-1:0]  mcand;
  logic [EW-1:0]  exp_sum;
  logic           sign_p;
  fpu_pkg::ieee_t next_product;

  assign start = stage_valid && stage.op == fpu_pkg::OP_MUL && !running;
  assign last  = running && step == CW'(`FPU_MUL_STEPS);

  // product is in [1,4), bump the exponent when bit 2^1 is set
  always_comb begin
    if (acc[2*RW-1]) next_product = '{sign: sign_p, exp: exp_sum + EW'(1),
                                      frac: acc[2*RW-2 -: FW]};
    else next_product = '{sign: sign_p, exp: exp_sum, frac: acc[2*RW-3 -: FW]};
  end

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      running       <= 1'b0;
      shift_ph      <= 1'b0;
      step          <= '0;
      product_valid <= 1'b0;
    end else begin
      product_valid <= 1'b0;
      if (start) begin
        running  <= 1'b1;
        shift_ph <= 1'b0;
        step     <= '0;
      end else if (last) begin
        running       <= 1'b0;
        product_valid <= 1'b1;
      end else if (running) begin
        shift_ph <= !shift_ph;
        if (shift_ph) step <= step + CW'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      acc     <= PW'(stage.b_raw);
      mcand   <= stage.a_raw;
      exp_sum <= stage.a_exp + stage.b_exp + EW'(`FPU_BIAS);
      sign_p  <= stage.a_sign ^ stage.b_sign;
    end else if (running && !last) begin
      if (shift_ph) acc <= acc >> 1;
      else if (acc[0]) acc[PW-1:RW] <= acc[PW-1:RW] + {1'b0, mcand};
    end
    if (last) product <= next_product;
  end

endmodule

/* hdl/fpu_pkg.sv */
// shared fpu types: the operation code and the structs handed from stage to stage
`include "fpu_config.svh"

package fpu_pkg;

  // codes 3 and up are legal on the bus and run as add
  typedef enum logic [3:0] {
    OP_ADD = `FPU_OP_ADD,
    OP_SUB = `FPU_OP_SUB,
    OP_MUL = `FPU_OP_MUL
  } fpu_op_e;

  typedef struct packed {
    logic                   sign;
    logic [`FPU_EXP_W-1:0]  exp;
    logic [`FPU_FRAC_W-1:0] frac;
  } ieee_t;

  // one command as issued by the register front end
  typedef struct packed {
    fpu_op_e op;
    ieee_t   a;
    ieee_t   b;
  } cmd_t;

  // unpack stage output, read by both the add/sub and the multiply stage
  typedef struct packed {
    fpu_op_e                      op;
    logic signed [`FPU_MANT_W-1:0] a_mant;
    logic signed [`FPU_MANT_W-1:0] b_mant;
    // common exponent after alignment, unbiased
    logic [`FPU_EXP_W-1:0]        exp;
    logic                         a_zero;
    // raw fields for the multiplier
    logic [`FPU_FRAC_W:0]         a_raw;
    logic [`FPU_FRAC_W:0]         b_raw;
    logic [`FPU_EXP_W-1:0]        a_exp;
    logic [`FPU_EXP_W-1:0]        b_exp;
    logic                         a_sign;
    logic                         b_sign;
  } aligned_t;

endpackage

/* hdl/fpu_regs.sv */
// byte-wide bus register file with readback and the command sequencer for busy and cmd_end
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_regs (
  input  logic              clk,
  input  logic              arst,
  input  logic [3:0]        addr,
  input  logic              cs,
  input  logic              rd,
  input  logic              wr,
  input  logic              end_ack,
  input  logic [7:0]        databus_in,
  input  fpu_pkg::ieee_t    result,
  input  logic              result_valid,
  output logic [7:0]        databus_out,
  output fpu_pkg::cmd_t     cmd,
  output logic              go,
  output logic              busy,
  output logic              cmd_end
);

  localparam int EW = `FPU_EXP_W;
  localparam int NB = `FPU_WIDTH / 8;
  localparam fpu_pkg::ieee_t ONE = '{sign: 1'b0, exp: EW'(`FPU_BIAS), frac: '0};

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_WAIT_ACK
  } state_e;

  state_e           state;
  fpu_pkg::ieee_t   opa;
  fpu_pkg::ieee_t   opb;
  fpu_pkg::ieee_t   res_q;
  fpu_pkg::fpu_op_e op_q;
  logic             start_req;
  logic             wr_en;
  logic             rd_en;
  logic [3:0]       a_off;
  logic [3:0]       b_off;
  logic [3:0]       r_off;
  logic             a_hit;
  logic             b_hit;
  logic             r_hit;

  assign wr_en = !cs && !wr;
  assign rd_en = !cs && !rd;

  // byte offsets inside each 32-bit register
  assign a_off = addr - `FPU_ADDR_OPA0;
  assign b_off = addr - `FPU_ADDR_OPB0;
  assign r_off = addr - `FPU_ADDR_RES0;
  assign a_hit = a_off < 4'(NB);
  assign b_hit = b_off < 4'(NB);
  assign r_hit = r_off < 4'(NB);

  assign cmd     = '{op: op_q, a: opa, b: opb};
  assign busy    = state != ST_IDLE;
  assign cmd_end = state == ST_WAIT_ACK;

  // -------------------------------------------------------------------------
  // register writes and sequencer
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      opa       <= ONE;
      opb       <= ONE;
      op_q      <= fpu_pkg::OP_ADD;
      res_q     <= '0;
      start_req <= 1'b0;
      go        <= 1'b0;
      state     <= ST_IDLE;
    end else begin
      go <= 1'b0;
      if (wr_en) begin
        if (a_hit) opa[{a_off[1:0], 3'b000} +: 8] <= databus_in;
        if (b_hit) opb[{b_off[1:0], 3'b000} +: 8] <= databus_in;
        if (addr == `FPU_ADDR_OP) op_q <= fpu_pkg::fpu_op_e'(databus_in[3:0]);
        // start while a command is in flight is dropped
        if (addr == `FPU_ADDR_START && state == ST_IDLE) start_req <= 1'b1;
      end
      case (state)
        ST_IDLE: begin
          if (start_req) begin
            start_req <= 1'b0;
            go        <= 1'b1;
            state     <= ST_RUN;
          end
        end
        ST_RUN: begin
          if (result_valid) begin
            res_q <= result;
            // chain the result into operand a
            opa   <= result;
            state <= ST_WAIT_ACK;
          end
        end
        ST_WAIT_ACK: begin
          if (end_ack) state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // -------------------------------------------------------------------------
  // readback, zero when not selected
  always_comb begin
    databus_out = '0;
    if (rd_en) begin
      if (a_hit) databus_out = opa[{a_off[1:0], 3'b000} +: 8];
      else if (b_hit) databus_out = opb[{b_off[1:0], 3'b000} +: 8];
      else if (addr == `FPU_ADDR_OP) databus_out = {4'b0000, op_q};
      else if (r_hit) databus_out = res_q[{r_off[1:0], 3'b000} +: 8];
    end
  end

endmodule

/* hdl/fpu_top.sv */
// fpu coprocessor top: bus front end feeding the unpack stage and the add/sub and multiply stages
`timescale 1ns/1ps

module fpu_top (
  input  logic       clk,
  input  logic       arst,
  input  logic [3:0] addr,
  input  logic       cs,
  input  logic       rd,
  input  logic       wr,
  input  logic       end_ack,
  input  logic [7:0] databus_in,
  output logic [7:0] databus_out,
  output logic       cmd_end,
  output logic       busy
);

  fpu_pkg::cmd_t     cmd;
  fpu_pkg::aligned_t stage;
  fpu_pkg::ieee_t    sum;
  fpu_pkg::ieee_t    product;
  fpu_pkg::ieee_t    result;
  logic              go;
  logic              stage_valid;
  logic              sum_valid;
  logic              product_valid;
  logic              result_valid;

  // only one stage finishes per command
  assign result       = product_valid ? product : sum;
  assign result_valid = sum_valid | product_valid;

  fpu_regs u_regs (
    .clk(clk), .arst(arst), .addr(addr), .cs(cs), .rd(rd), .wr(wr),
    .end_ack(end_ack), .databus_in(databus_in), .result(result),
    .result_valid(result_valid), .databus_out(databus_out), .cmd(cmd),
    .go(go), .busy(busy), .cmd_end(cmd_end)
  );

  fpu_unpack u_unpack (
    .clk(clk), .arst(arst), .cmd(cmd), .go(go), .stage(stage), .stage_valid(stage_valid)
  );

  fpu_addsub u_addsub (
    .clk(clk), .arst(arst), .stage(stage), .stage_valid(stage_valid),
    .sum(sum), .sum_valid(sum_valid)
  );

  fpu_mul u_mul (
    .clk(clk), .arst(arst), .stage(stage), .stage_valid(stage_valid),
    .product(product), .product_valid(product_valid)
  );

endmodule

/* hdl/fpu_unpack.sv */
// unpack stage: splits both operands into fields and aligns the mantissas for add/sub
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_unpack (
  input  logic                clk,
  input  logic                arst,
  input  fpu_pkg::cmd_t       cmd,
  input  logic                go,
  output fpu_pkg::aligned_t   stage,
  output logic                stage_valid
);

  localparam int EW = `FPU_EXP_W;
  localparam int MW = `FPU_MANT_W;
  localparam int RW = `FPU_FRAC_W + 1;

  logic [RW-1:0]     a_raw;
  logic [RW-1:0]     b_raw;
  logic [EW-1:0]     shift;
  logic              a_ge_b;
  logic [MW-1:0]     a_al;
  logic [MW-1:0]     b_al;
  fpu_pkg::aligned_t next_stage;

  // hidden bit only for normal numbers
  assign a_raw  = {|cmd.a.exp, cmd.a.frac};
  assign b_raw  = {|cmd.b.exp, cmd.b.frac};
  assign a_ge_b = cmd.a.exp >= cmd.b.exp;
  assign shift  = a_ge_b ? cmd.a.exp - cmd.b.exp : cmd.b.exp - cmd.a.exp;

  always_comb begin
    a_al = MW'(a_raw);
    b_al = MW'(b_raw);
    // smaller exponent moves right
    if (a_ge_b) b_al = b_al >> shift;
    else a_al = a_al >> shift;
    next_stage.op     = cmd.op;
    next_stage.a_mant = cmd.a.sign ? -a_al : a_al;
    next_stage.b_mant = cmd.b.sign ? -b_al : b_al;
    next_stage.a_exp  = cmd.a.exp - EW'(`FPU_BIAS);
    next_stage.b_exp  = cmd.b.exp - EW'(`FPU_BIAS);
    next_stage.exp    = a_ge_b ? next_stage.a_exp : next_stage.b_exp;
    next_stage.a_zero = ~|{cmd.a.exp, cmd.a.frac};
    next_stage.a_raw  = a_raw;
    next_stage.b_raw  = b_raw;
    next_stage.a_sign = cmd.a.sign;
    next_stage.b_sign = cmd.b.sign;
  end

  always_ff @(posedge clk or posedge arst) begin
    if (arst) stage_valid <= 1'b0;
    else stage_valid <= go;
  end

  always_ff @(posedge clk) begin
    if (go) stage <= next_stage;
  end

endmodule

/* src.f */
+incdir+hdl
hdl/fpu_pkg.sv
hdl/fpu_regs.sv
hdl/fpu_unpack.sv
hdl/fpu_addsub.sv
hdl/fpu_mul.sv
hdl/fpu_top.sv
verif/tb_fpu.sv

/* verif/tb_fpu.sv */
// testbench for fpu_top: runs a table of bus commands and checks results, status and chaining
`timescale 1ns/1ps
`include "fpu_config.svh"

module tb_fpu;

  typedef struct packed {
    logic [3:0]  op;
    logic        keep_a;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] expected;
  } vector_t;

  localparam int N_VEC           = 8;
  localparam int CMD_LIMIT       = 200;
  localparam int WATCHDOG_CYCLES = N_VEC * 80 + 200;

  logic       clk = 1'b0;
  logic       arst;
  logic [3:0] addr;
  logic       cs;
  logic       rd;
  logic       wr;
  logic       end_ack;
  logic [7:0] databus_in;
  logic [7:0] databus_out;
  logic       cmd_end;
  logic       busy;
  vector_t    vectors [N_VEC];
  int         checks = 0;
  int         errors = 0;
  int         timeouts = 0;

  fpu_top UUT (
    .clk(clk), .arst(arst), .addr(addr), .cs(cs), .rd(rd), .wr(wr),
    .end_ack(end_ack), .databus_in(databus_in), .databus_out(databus_out),
    .cmd_end(cmd_end), .busy(busy)
  );

  always #5 clk = ~clk;

  // -------------------------------------------------------------------------
  // bus access, byte 0 at the base address
  task automatic write_bytes(input logic [3:0] base, input logic [31:0] data, input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      cs         <= 1'b0;
      wr         <= 1'b0;
      addr       <= base + 4'(i);
      databus_in <= data[8*i +: 8];
    end
    @(posedge clk);
    cs <= 1'b1;
    wr <= 1'b1;
  endtask

  task automatic read_bytes(input logic [3:0] base, input int n, output logic [31:0] data);
    data = '0;
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      cs   <= 1'b0;
      rd   <= 1'b0;
      addr <= base + 4'(i);
      @(negedge clk);
      data[8*i +: 8] = databus_out;
    end
    @(posedge clk);
    cs <= 1'b1;
    rd <= 1'b1;
  endtask

  task automatic compare_word(input string what, input int idx, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("Error at %0t: %s (vector %0d) is %h, expected %h", $time, what, idx, got, exp);
    end
  endtask

  // -------------------------------------------------------------------------
  // one table entry: load, start, wait, hold off the ack, read back, ack
  task automatic run_vector(input vector_t v, input int idx);
    logic [31:0] got;
    int          cycles;
    logic        done;
    if (!v.keep_a) write_bytes(`FPU_ADDR_OPA0, v.a, 4);
    write_bytes(`FPU_ADDR_OPB0, v.b, 4);
    write_bytes(`FPU_ADDR_OP, {28'h0, v.op}, 1);
    write_bytes(`FPU_ADDR_START, 32'h1, 1);
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < CMD_LIMIT) begin
      @(negedge clk);
      cycles++;
      done = cmd_end;
      if (!done && cycles > 1) compare_word("busy while running", idx, 32'(busy), 32'h1);
    end
    if (!done) begin
      timeouts++;
      $display("vector %0d: the command never finished, cmd_end did not rise", idx);
    end else if (v.op != `FPU_OP_MUL) begin
      // sample n sees the state after edge n-1 past the start write
      compare_word("cycles from start to cmd_end", idx, 32'(cycles - 1), 32'd4);
    end
    // no ack yet, status has to hold
    repeat (3) begin
      @(negedge clk);
      compare_word("busy/cmd_end without ack", idx, {30'h0, busy, cmd_end}, 32'h3);
    end
    write_bytes(`FPU_ADDR_START, 32'h1, 1);
    read_bytes(`FPU_ADDR_RES0, 4, got);
    compare_word("result", idx, got, v.expected);
    read_bytes(`FPU_ADDR_OPA0, 4, got);
    compare_word("operand a after chaining", idx, got, v.expected);
    @(posedge clk);
    end_ack <= 1'b1;
    @(posedge clk);
    end_ack <= 1'b0;
    repeat (3) begin
      @(negedge clk);
      compare_word("busy/cmd_end after ack", idx, {30'h0, busy, cmd_end}, 32'h0);
    end
  endtask

  initial begin
    logic [31:0] got;
    arst       <= 1'b1;
    cs         <= 1'b1;
    wr         <= 1'b1;
    rd         <= 1'b1;
    addr       <= '0;
    end_ack    <= 1'b0;
    databus_in <= '0;
    // op, keep a, a, b, expected
    vectors[0] = '{`FPU_OP_ADD, 1'b0, 32'h3F800000, 32'h40000000, 32'h40400000};
    vectors[1] = '{`FPU_OP_ADD, 1'b0, 32'h40400000, 32'hBE800000, 32'h40300000};
    vectors[2] = '{`FPU_OP_SUB, 1'b0, 32'h40000000, 32'h40A00000, 32'hC0400000};
    vectors[3] = '{`FPU_OP_SUB, 1'b0, 32'h3FC00000, 32'h3FC00000, 32'h00000000};
    vectors[4] = '{`FPU_OP_MUL, 1'b0, 32'h3FC00000, 32'h40200000, 32'h40700000};
    vectors[5] = '{`FPU_OP_MUL, 1'b0, 32'h40E00000, 32'h40A00000, 32'h420C0000};
    vectors[6] = '{`FPU_OP_MUL, 1'b0, 32'hC0400000, 32'h3E800000, 32'hBF400000};
    // reuses -0.75 left in operand a
    vectors[7] = '{`FPU_OP_ADD, 1'b1, 32'hBF400000, 32'h3F800000, 32'h3E800000};
    repeat (8) @(posedge clk);
    arst <= 1'b0;
    @(negedge clk);
    compare_word("busy/cmd_end after reset", -1, {30'h0, busy, cmd_end}, 32'h0);
    read_bytes(`FPU_ADDR_OPA0, 4, got);
    compare_word("operand a after reset", -1, got, 32'h3F800000);
    read_bytes(`FPU_ADDR_OPB0, 4, got);
    compare_word("operand b after reset", -1, got, 32'h3F800000);
    read_bytes(`FPU_ADDR_OP, 1, got);
    compare_word("operation after reset", -1, got, 32'h0);
    for (int i = 0; i < N_VEC; i++) run_vector(vectors[i], i);
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule
